// ==== list.f ====
rtl/adc_rx_pkg.sv
rtl/adc_sample_delay.sv
rtl/adc_record_ctrl.sv
rtl/adc_word_pack.sv
rtl/adc_sample_fifo.sv
rtl/adc_rx_top.sv
testbench/tb_adc_rx.sv

// ==== rtl/adc_record_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_record_ctrl (
    input  wire                          ADC_ENC,
    input  wire                          rst_adc_sync,
    input  wire adc_rx_pkg::adc_rx_cfg_t cfg,
    input  wire                          start,
    input  wire                          adc_sync,
    input  wire                          adc_trigger,
    input  wire                          thr_hit,
    output adc_rx_pkg::adc_rec_t         rec,
    output logic                         done
);
    import adc_rx_pkg::*;

    logic             sync_q;
    logic             sync_rise;
    logic             sync_wait;
    logic             start_evt;
    logic             finished;
    logic             go;
    logic             active;
    logic             phase_q;
    logic [CNT_W-1:0] rec_cnt;

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            sync_q <= 1'b0;
        end else begin
            sync_q <= adc_sync;
        end
    end

    assign sync_rise = adc_sync & ~sync_q;

    // armed by start, released by the next sync edge
    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            sync_wait <= 1'b0;
        end else if (start) begin
            sync_wait <= 1'b1;
        end else if (sync_rise) begin
            sync_wait <= 1'b0;
        end
    end

    assign start_evt = (cfg.start_with_sync ? (sync_wait & sync_rise) : start)
                     | (cfg.en_ex_trigger & adc_trigger)
                     | (cfg.en_threshold & thr_hit);

    assign finished = (cfg.data_cnt != '0) && (rec_cnt > cfg.data_cnt);
    assign go       = start_evt && (rec_cnt == '0 || finished);

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            rec_cnt <= '0;
        end else if (go) begin
            rec_cnt <= CNT_W'(1);
        end else if (rec_cnt != '0 && rec_cnt != '1 && !finished) begin
            rec_cnt <= rec_cnt + 1'b1;   // holds at all ones when forever
        end
    end

    assign active = (rec_cnt != '0) && (cfg.data_cnt == '0 || rec_cnt <= cfg.data_cnt);

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync || go) begin
            phase_q <= 1'b0;
        end else if (active) begin
            phase_q <= ~phase_q;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            done <= 1'b1;
        end else if (start || go) begin
            done <= 1'b0;
        end else if (active && cfg.data_cnt != '0 && rec_cnt == cfg.data_cnt) begin
            done <= 1'b1;   // last sample this cycle
        end
    end

    assign rec.active = active;
    assign rec.first  = rec_cnt == CNT_W'(1);
    assign rec.phase  = active & phase_q;

    a_no_done_while_active : assert property (
        @(posedge ADC_ENC) disable iff (rst_adc_sync) !(rec.active && done));

endmodule

`default_nettype wire

// ==== rtl/adc_rx_pkg.sv ====
`default_nettype none

package adc_rx_pkg;

    localparam int SAMPLE_W = 14;
    localparam int WORD_W   = 32;
    localparam int CNT_W    = 24;
    localparam int DLY_W    = 8;   // delay memory has 2**DLY_W entries
    localparam int FIFO_AW  = 4;   // 16 words

    // configuration levels, held stable during a recording
    typedef struct packed {
        logic                start_with_sync;
        logic                en_ex_trigger;
        logic                en_threshold;
        logic                single_data;
        logic [CNT_W-1:0]    data_cnt;      // 0 = record forever
        logic [DLY_W-1:0]    sample_dly;
        logic [SAMPLE_W-1:0] threshold;
    } adc_rx_cfg_t;

    typedef struct packed {
        logic active;   // record window open
        logic first;    // first sample of a recording
        logic phase;    // second sample of a pair
    } adc_rec_t;

    typedef struct packed {
        logic [0:0]          header_id;
        logic [1:0]          adc_id;
        logic                mark;
        logic [13:0]         pad;
        logic [SAMPLE_W-1:0] sample;
    } adc_single_t;

    typedef struct packed {
        logic [0:0]          header_id;
        logic [1:0]          adc_id;
        logic                sync;   // sync of the older sample
        logic [SAMPLE_W-1:0] older;
        logic [SAMPLE_W-1:0] newer;
    } adc_pair_t;

    // one output word, layout depends on single_data
    typedef union packed {
        adc_single_t single;
        adc_pair_t   pair;
    } adc_word_u;

endpackage

`default_nettype wire

// ==== rtl/adc_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_rx_top #(
    parameter logic [0:0] HEADER_ID = 1'b0,
    parameter logic [1:0] ADC_ID    = 2'd0
) (
    input  wire                              ADC_ENC,
    input  wire                              rst_adc_sync,
    input  wire  [adc_rx_pkg::SAMPLE_W-1:0]  adc_in,
    input  wire                              adc_sync,
    input  wire                              adc_trigger,
    input  wire                              start,
    input  wire adc_rx_pkg::adc_rx_cfg_t     cfg,
    input  wire                              fifo_read,
    output logic [adc_rx_pkg::WORD_W-1:0]    fifo_data,
    output logic                             fifo_empty,
    output logic [7:0]                       lost_count,
    output logic                             done
);
    import adc_rx_pkg::*;

    logic [SAMPLE_W-1:0] sample_dly;
    logic                thr_hit;
    adc_rec_t            rec;
    logic                wr;
    adc_word_u           word;

    adc_sample_delay u_adc_sample_delay (
        .ADC_ENC      (ADC_ENC),
        .rst_adc_sync (rst_adc_sync),
        .cfg          (cfg),
        .adc_in       (adc_in),
        .sample_dly   (sample_dly),
        .thr_hit      (thr_hit)
    );

    adc_record_ctrl u_adc_record_ctrl (
        .ADC_ENC      (ADC_ENC),
        .rst_adc_sync (rst_adc_sync),
        .cfg          (cfg),
        .start        (start),
        .adc_sync     (adc_sync),
        .adc_trigger  (adc_trigger),
        .thr_hit      (thr_hit),
        .rec          (rec),
        .done         (done)
    );

    adc_word_pack #(
        .HEADER_ID (HEADER_ID),
        .ADC_ID    (ADC_ID)
    ) u_adc_word_pack (
        .ADC_ENC    (ADC_ENC),
        .cfg        (cfg),
        .rec        (rec),
        .sample_dly (sample_dly),
        .adc_sync   (adc_sync),
        .wr         (wr),
        .word       (word)
    );

    adc_sample_fifo u_adc_sample_fifo (
        .ADC_ENC      (ADC_ENC),
        .rst_adc_sync (rst_adc_sync),
        .wr           (wr),
        .word         (word),
        .fifo_read    (fifo_read),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .lost_count   (lost_count)
    );

endmodule

`default_nettype wire

// ==== rtl/adc_sample_delay.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_sample_delay (
    input  wire                                ADC_ENC,
    input  wire                                rst_adc_sync,
    input  wire adc_rx_pkg::adc_rx_cfg_t       cfg,
    input  wire  [adc_rx_pkg::SAMPLE_W-1:0]    adc_in,
    output logic [adc_rx_pkg::SAMPLE_W-1:0]    sample_dly,
    output logic                               thr_hit
);
    import adc_rx_pkg::*;

    logic [SAMPLE_W-1:0] dly_mem [0:(1<<DLY_W)-1];
    logic [DLY_W-1:0]    wr_addr;
    logic [DLY_W-1:0]    rd_addr;
    logic [SAMPLE_W-1:0] rd_q;

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            wr_addr <= '0;
        end else begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        dly_mem[wr_addr] <= adc_in;
    end

    // read register adds one cycle, so look one entry closer to the write side
    assign rd_addr = wr_addr - cfg.sample_dly + 1'b1;

    always_ff @(posedge ADC_ENC) begin
        if (cfg.sample_dly == DLY_W'(1)) begin
            rd_q <= adc_in;   // entry is being written this cycle
        end else begin
            rd_q <= dly_mem[rd_addr];
        end
    end

    always_comb begin
        if (cfg.sample_dly == '0) begin
            sample_dly = adc_in;   // no delay, direct path
        end else begin
            sample_dly = rd_q;
        end
    end

    assign thr_hit = sample_dly < cfg.threshold;

endmodule

`default_nettype wire

// ==== rtl/adc_sample_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_sample_fifo (
    input  wire                              ADC_ENC,
    input  wire                              rst_adc_sync,
    input  wire                              wr,
    input  wire adc_rx_pkg::adc_word_u       word,
    input  wire                              fifo_read,
    output logic [adc_rx_pkg::WORD_W-1:0]    fifo_data,
    output logic                             fifo_empty,
    output logic [7:0]                       lost_count
);
    import adc_rx_pkg::*;

    logic [WORD_W-1:0] mem [0:(1<<FIFO_AW)-1];
    logic [FIFO_AW:0]  wr_ptr;   // msb is the wrap bit
    logic [FIFO_AW:0]  rd_ptr;
    logic              full;
    logic              push;
    logic              pop;

    assign fifo_empty = wr_ptr == rd_ptr;
    assign full       = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW])
                     && (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign push       = wr & ~full;
    assign pop        = fifo_read & ~fifo_empty;

    always_ff @(posedge ADC_ENC) begin
        if (push) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= word;
        end
    end

    assign fifo_data = mem[rd_ptr[FIFO_AW-1:0]];   // head word, fall-through

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (rst_adc_sync) begin
            lost_count <= '0;
        end else if (wr && full && lost_count != 8'hff) begin
            lost_count <= lost_count + 1'b1;   // saturates
        end
    end

    a_no_pop_when_empty : assert property (
        @(posedge ADC_ENC) disable iff (rst_adc_sync) fifo_empty |=> $stable(rd_ptr));

endmodule

`default_nettype wire

// ==== rtl/adc_word_pack.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_word_pack #(
    parameter logic [0:0] HEADER_ID = 1'b0,
    parameter logic [1:0] ADC_ID    = 2'd0
) (
    input  wire                              ADC_ENC,
    input  wire adc_rx_pkg::adc_rx_cfg_t     cfg,
    input  wire adc_rx_pkg::adc_rec_t        rec,
    input  wire  [adc_rx_pkg::SAMPLE_W-1:0]  sample_dly,
    input  wire                              adc_sync,
    output logic                             wr,
    output adc_rx_pkg::adc_word_u            word
);
    import adc_rx_pkg::*;

    logic [SAMPLE_W-1:0] prev_sample;
    logic                prev_sync;

    always_ff @(posedge ADC_ENC) begin
        prev_sample <= sample_dly;
        prev_sync   <= adc_sync;
    end

    always_comb begin
        if (cfg.single_data) begin
            word.single.header_id = HEADER_ID;
            word.single.adc_id    = ADC_ID;
            // trigger modes flag the first sample, otherwise pass sync through
            if (cfg.en_ex_trigger || cfg.en_threshold) begin
                word.single.mark = rec.first;
            end else begin
                word.single.mark = adc_sync;
            end
            word.single.pad    = '0;
            word.single.sample = sample_dly;
            wr = rec.active;
        end else begin
            word.pair.header_id = HEADER_ID;
            word.pair.adc_id    = ADC_ID;
            word.pair.sync      = prev_sync;
            word.pair.older     = prev_sample;
            word.pair.newer     = sample_dly;
            wr = rec.active & rec.phase;   // every second sample
        end
    end

    // a pair word never carries a sample from outside the window
    a_wr_in_window : assert property (
        @(posedge ADC_ENC) wr |-> rec.active && (cfg.single_data || $past(rec.active)));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the capture channel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f list.f --top-module tb_adc_rx -Mdir obj_dir -o tb_adc_rx

./obj_dir/tb_adc_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// ==== testbench/adc_rx_stimulus.txt ====
# kind single data_cnt sample_dly threshold drain expected_words
# kind 0 start strobe, 1 start with sync, 2 external trigger, 3 threshold
3 1 24 4 48 1 24
0 1 12 0 0 1 12
0 1 20 7 0 1 20
0 0 32 3 0 1 16
1 1 10 2 0 0 10
1 0 16 0 0 1 8
2 1 14 5 0 1 14
2 0 12 1 0 0 6
0 1 40 0 0 0 16
0 0 20 9 0 0 10

// ==== testbench/tb_adc_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_adc_rx;
    import adc_rx_pkg::*;

    localparam logic [0:0] HDR_ID    = 1'b1;
    localparam logic [1:0] CHAN_ID   = 2'd2;
    localparam int         MAX_TESTS = 16;
    localparam int         HIST_MASK = 1023;
    localparam int         FIFO_WORDS = 16;

    logic                ADC_ENC = 1'b0;
    logic                rst_adc_sync;
    logic [SAMPLE_W-1:0] adc_in;
    logic                adc_sync;
    logic                adc_trigger;
    logic                start;
    adc_rx_cfg_t         cfg;
    logic                fifo_read;
    logic [WORD_W-1:0]   fifo_data;
    logic                fifo_empty;
    logic [7:0]          lost_count;
    logic                done;

    // one row per test, columns as in the stimulus file
    int t_kind [0:MAX_TESTS-1];
    int t_single [0:MAX_TESTS-1];
    int t_cnt [0:MAX_TESTS-1];
    int t_dly [0:MAX_TESTS-1];
    int t_thr [0:MAX_TESTS-1];
    int t_drain [0:MAX_TESTS-1];
    int t_expect [0:MAX_TESTS-1];

    int                  n_tests = 0;
    int                  n_failed = 0;
    int                  n_errors = 0;
    int                  wd_cycles = 0;
    int                  cyc = 0;
    int                  sync_pulse_at = -1;
    bit                  sync_periodic = 1'b1;
    bit                  draining = 1'b0;
    logic [SAMPLE_W-1:0] adc_val = 14'd16264;   // wraps to zero in cycle 40
    logic [SAMPLE_W-1:0] hist [0:HIST_MASK];
    logic                sync_hist [0:HIST_MASK];
    logic [WORD_W-1:0]   rx_q [$];

    adc_rx_top #(
        .HEADER_ID (HDR_ID),
        .ADC_ID    (CHAN_ID)
    ) u_adc_rx_top (
        .ADC_ENC      (ADC_ENC),
        .rst_adc_sync (rst_adc_sync),
        .adc_in       (adc_in),
        .adc_sync     (adc_sync),
        .adc_trigger  (adc_trigger),
        .start        (start),
        .cfg          (cfg),
        .fifo_read    (fifo_read),
        .fifo_data    (fifo_data),
        .fifo_empty   (fifo_empty),
        .lost_count   (lost_count),
        .done         (done)
    );

    always #50 ADC_ENC = ~ADC_ENC;

    // advance one cycle, drive the free-running inputs and pop words when draining
    task automatic next_cycle();
        @(posedge ADC_ENC);
        #1;
        cyc = cyc + 1;
        adc_val = adc_val + 14'd3;
        adc_in = adc_val;
        if (sync_periodic) begin
            adc_sync = (cyc % 5 == 0);
        end else begin
            adc_sync = (cyc == sync_pulse_at);
        end
        hist[cyc & HIST_MASK] = adc_val;
        sync_hist[cyc & HIST_MASK] = adc_sync;
        start = 1'b0;
        adc_trigger = 1'b0;
        fifo_read = 1'b0;
        if (draining && !fifo_empty && ($urandom % 8) != 0) begin
            fifo_read = 1'b1;
            rx_q.push_back(fifo_data);   // head word of this cycle
        end
    endtask

    function automatic logic [SAMPLE_W-1:0] delayed_sample(input int n, input int d);
        return hist[(n - d) & HIST_MASK];
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        n_errors = n_errors + 1;
    endtask

    task automatic run_test(input int ti);
        int          kind;
        int          cnt;
        int          dly;
        int          ev;
        int          t;
        int          written;
        int          exp_lost;
        int          first_err;
        logic        m;
        logic [31:0] exp_w;

        kind = t_kind[ti];
        cnt = t_cnt[ti];
        dly = t_dly[ti];
        first_err = n_errors;
        rx_q.delete();
        draining = 1'b0;
        sync_periodic = (kind != 1);
        sync_pulse_at = -1;
        cfg = '0;
        cfg.start_with_sync = (kind == 1);
        cfg.single_data = (t_single[ti] != 0);
        cfg.data_cnt = CNT_W'(cnt);
        cfg.sample_dly = DLY_W'(dly);
        cfg.threshold = SAMPLE_W'(t_thr[ti]);
        rst_adc_sync = 1'b1;
        repeat (5) next_cycle();
        rst_adc_sync = 1'b0;
        if (done !== 1'b1 || fifo_empty !== 1'b1 || lost_count !== 8'd0) begin
            report_error("reset state wrong");
        end
        repeat (dly + 3) next_cycle();   // fill the delay line
        draining = (t_drain[ti] != 0);

        if (kind == 0) begin
            start = 1'b1;
            ev = cyc;
        end else if (kind == 1) begin
            start = 1'b1;
            sync_pulse_at = cyc + 6;
            repeat (6) begin
                next_cycle();
                if (fifo_empty !== 1'b1) report_error("word before sync edge");
            end
            ev = cyc;
        end else if (kind == 2) begin
            cfg.en_ex_trigger = 1'b1;
            repeat (3) next_cycle();
            adc_trigger = 1'b1;
            ev = cyc;
        end else begin
            cfg.en_threshold = 1'b1;
            ev = -1;
            while (ev < 0) begin
                if (int'(delayed_sample(cyc, dly)) < t_thr[ti]) ev = cyc;
                else next_cycle();
            end
        end

        next_cycle();
        if (done !== 1'b0) report_error("done still high after start event");
        while (done !== 1'b1) next_cycle();
        if (cyc != ev + cnt + 1) begin
            report_error($sformatf("done rose in cycle %0d, expected %0d", cyc, ev + cnt + 1));
        end
        cfg.en_ex_trigger = 1'b0;
        cfg.en_threshold = 1'b0;   // no retrigger while draining
        draining = 1'b1;
        next_cycle();
        while (fifo_empty !== 1'b1) next_cycle();
        draining = 1'b0;

        written = cfg.single_data ? cnt : cnt / 2;
        exp_lost = (t_drain[ti] == 0 && written > FIFO_WORDS) ? written - FIFO_WORDS : 0;
        if (rx_q.size() != t_expect[ti]) begin
            report_error($sformatf("got %0d words, expected %0d", rx_q.size(), t_expect[ti]));
        end
        if (lost_count !== 8'(exp_lost)) begin
            report_error($sformatf("lost_count %0d, expected %0d", lost_count, exp_lost));
        end
        for (int i = 0; i < rx_q.size() && i < t_expect[ti]; i++) begin
            if (cfg.single_data) begin
                t = ev + 1 + i;
                if (kind >= 2) m = (i == 0);
                else m = sync_hist[t & HIST_MASK];
                exp_w = {HDR_ID, CHAN_ID, m, 14'd0, delayed_sample(t, dly)};
            end else begin
                t = ev + 1 + 2 * i;   // older sample of the pair
                exp_w = {HDR_ID, CHAN_ID, sync_hist[t & HIST_MASK],
                         delayed_sample(t, dly), delayed_sample(t + 1, dly)};
            end
            if (rx_q[i] !== exp_w) begin
                report_error($sformatf("word %0d is %h, expected %h", i, rx_q[i], exp_w));
            end
        end

        if (n_errors != first_err) n_failed = n_failed + 1;
        $display("test %0d kind %0d single %0d cnt %0d dly %0d: %0d words, lost %0d, %s",
                 ti, kind, t_single[ti], cnt, dly, rx_q.size(), lost_count,
                 (n_errors == first_err) ? "ok" : "errors");
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge ADC_ENC);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int    fd;
        int    k;
        int    s;
        int    cn;
        int    dl;
        int    th;
        int    dr;
        int    ex;
        int    total;
        string line;

        rst_adc_sync = 1'b1;
        adc_in = adc_val;
        adc_sync = 1'b0;
        adc_trigger = 1'b0;
        start = 1'b0;
        cfg = '0;
        fifo_read = 1'b0;
        void'($urandom(16454));
        total = 0;
        fd = $fopen("testbench/adc_rx_stimulus.txt", "r");
        if (fd == 0) $display("cannot open the stimulus file");
        while (fd != 0 && !$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%d %d %d %d %d %d %d", k, s, cn, dl, th, dr, ex) == 7) begin
                    t_kind[n_tests] = k;
                    t_single[n_tests] = s;
                    t_cnt[n_tests] = cn;
                    t_dly[n_tests] = dl;
                    t_thr[n_tests] = th;
                    t_drain[n_tests] = dr;
                    t_expect[n_tests] = ex;
                    total = total + cn + dl + 64;
                    n_tests = n_tests + 1;
                end
            end
        end
        if (fd != 0) $fclose(fd);
        wd_cycles = total;

        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end

        $display("summary: %0d tests, %0d failed, %0d check errors", n_tests, n_failed, n_errors);
        if (n_errors == 0 && n_tests > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
